// ==== src/addsub_defines.svh ====
// Widths and testbench limits for the add/subtract block, included by the package and bench
`ifndef ADDSUB_DEFINES_SVH
`define ADDSUB_DEFINES_SVH

// Width of one I or Q lane of an sc16 sample
`define ADDSUB_SAMP_W 16

// Context word and its tuser (header word type)
`define ADDSUB_CTX_W  64
`define ADDSUB_USER_W 4

// ------------------------------
// Limits seen by the testbench
// ------------------------------
`define ADDSUB_NUM_PKTS    40
`define ADDSUB_MAX_PKT_LEN 16
`define ADDSUB_CTX_PER_PKT 2
// Cycles allowed per beat before the run is declared hung
`define ADDSUB_CYC_PER_BEAT 8

`endif

// ==== src/addsub_pkg.sv ====
// Shared sample and context types for the add/subtract block, imported by RTL and bench
package addsub_pkg;

  `include "addsub_defines.svh"

  // ------------------------------
  // Sample types
  // ------------------------------

  // One signed I or Q lane, wraps in two's complement
  typedef logic signed [`ADDSUB_SAMP_W-1:0] iq_t;

  // One complex sc16 sample
  // Q sits in the upper half, I in the lower half
  typedef logic [2*`ADDSUB_SAMP_W-1:0] sc16_t;

  // ------------------------------
  // Context types
  // ------------------------------

  // One packet header / context word
  typedef logic [`ADDSUB_CTX_W-1:0] ctx_t;

  // Context tuser, carries the header word type
  typedef logic [`ADDSUB_USER_W-1:0] ctx_user_t;

endpackage

// ==== src/addsub_ifs.sv ====
// Sample and context stream interfaces used to wire the add/subtract block internally

// ------------------------------
// sc16 payload stream
// ------------------------------
interface sample_stream_if
  import addsub_pkg::*;
();

  // One sc16 beat plus framing
  sc16_t tdata;
  logic  tlast;
  // Handshake, a beat moves when both are high on a clk edge
  logic  tvalid;
  logic  tready;

  // Producer side
  modport src (
    output tdata,
    output tlast,
    output tvalid,
    input  tready
  );

  // Consumer side
  modport dst (
    input  tdata,
    input  tlast,
    input  tvalid,
    output tready
  );

endinterface

// ------------------------------
// Context (header) stream
// ------------------------------
interface ctx_stream_if
  import addsub_pkg::*;
();

  ctx_t      tdata;
  // Header word type
  ctx_user_t tuser;
  logic      tlast;
  logic      tvalid;
  logic      tready;

  modport src (
    output tdata,
    output tuser,
    output tlast,
    output tvalid,
    input  tready
  );

  modport dst (
    input  tdata,
    input  tuser,
    input  tlast,
    input  tvalid,
    output tready
  );

endinterface

// ==== src/addsub_core.sv ====
// Joins sc16 streams A and B and registers the lane-wise wrapped sum and difference
module addsub_core
  import addsub_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  // Payload inputs
  sample_stream_if.dst in_a,
  sample_stream_if.dst in_b,
  // Payload outputs
  sample_stream_if.src sum,
  sample_stream_if.src diff
);

  // ------------------------------
  // Lane split and arithmetic
  // ------------------------------

  // Input lanes
  iq_t   a_i;
  iq_t   a_q;
  iq_t   b_i;
  iq_t   b_q;

  // Result lanes, wrapped to lane width
  iq_t   sum_i;
  iq_t   sum_q;
  iq_t   diff_i;
  iq_t   diff_q;

  // Output slot registers
  sc16_t sum_data;
  sc16_t diff_data;
  logic  sum_last;
  logic  diff_last;
  logic  sum_vld;
  logic  diff_vld;

  // Join control
  logic  sum_free;
  logic  diff_free;
  logic  pair_take;

  // I in the low half, Q in the high half
  assign a_i = iq_t'(in_a.tdata[`ADDSUB_SAMP_W-1:0]);
  assign a_q = iq_t'(in_a.tdata[2*`ADDSUB_SAMP_W-1:`ADDSUB_SAMP_W]);
  assign b_i = iq_t'(in_b.tdata[`ADDSUB_SAMP_W-1:0]);
  assign b_q = iq_t'(in_b.tdata[2*`ADDSUB_SAMP_W-1:`ADDSUB_SAMP_W]);

  // Plain modulo 2^16 math, no saturation
  assign sum_i  = a_i + b_i;
  assign sum_q  = a_q + b_q;
  assign diff_i = a_i - b_i;
  assign diff_q = a_q - b_q;

  // ------------------------------
  // Join logic
  // ------------------------------

  // A slot can take a beat when it is empty or is draining this edge
  assign sum_free  = !sum_vld  || sum.tready;
  assign diff_free = !diff_vld || diff.tready;

  // A and B only move together, and only when both slots can load
  assign pair_take = in_a.tvalid && in_b.tvalid && sum_free && diff_free;

  assign in_a.tready = pair_take;
  assign in_b.tready = pair_take;

  // ------------------------------
  // Output slots
  // ------------------------------

  // Valid flags, each one cleared by its own ready
  always_ff @(posedge clk) begin
    if (rst) begin
      sum_vld  <= 1'b0;
      diff_vld <= 1'b0;
    end else begin
      if (pair_take) begin
        sum_vld <= 1'b1;
      end else if (sum.tready) begin
        sum_vld <= 1'b0;
      end
      if (pair_take) begin
        diff_vld <= 1'b1;
      end else if (diff.tready) begin
        diff_vld <= 1'b0;
      end
    end
  end

  // Payload loads only on a taken pair so a held beat stays stable
  always_ff @(posedge clk) begin
    if (pair_take) begin
      sum_data  <= {sum_q, sum_i};
      diff_data <= {diff_q, diff_i};
      // Framing follows stream A
      sum_last  <= in_a.tlast;
      diff_last <= in_a.tlast;
    end
  end

  assign sum.tdata   = sum_data;
  assign sum.tlast   = sum_last;
  assign sum.tvalid  = sum_vld;

  assign diff.tdata  = diff_data;
  assign diff.tlast  = diff_last;
  assign diff.tvalid = diff_vld;

endmodule

// ==== src/ctx_split.sv ====
// Registers each context beat of stream A and hands one copy to each output stream
module ctx_split
  import addsub_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  // Context from stream A
  ctx_stream_if.dst in_ctx,
  // Copies for the sum and difference streams
  ctx_stream_if.src out_a,
  ctx_stream_if.src out_b
);

  // ------------------------------
  // Held beat and pending flags
  // ------------------------------

  ctx_t      ctx_data;
  ctx_user_t ctx_user;
  logic      ctx_last;

  // Set while that output still owes the held beat
  logic      pend_a;
  logic      pend_b;

  logic      take;

  // Free when nothing is owed or every owed copy leaves this edge
  assign in_ctx.tready = (!pend_a || out_a.tready) && (!pend_b || out_b.tready);
  assign take          = in_ctx.tvalid && in_ctx.tready;

  always_ff @(posedge clk) begin
    if (rst) begin
      pend_a <= 1'b0;
      pend_b <= 1'b0;
    end else begin
      // New beat owes both copies
      if (take) begin
        pend_a <= 1'b1;
      end else if (out_a.tready) begin
        pend_a <= 1'b0;
      end
      if (take) begin
        pend_b <= 1'b1;
      end else if (out_b.tready) begin
        pend_b <= 1'b0;
      end
    end
  end

  // Beat register, tuser and tlast ride along unchanged
  always_ff @(posedge clk) begin
    if (take) begin
      ctx_data <= in_ctx.tdata;
      ctx_user <= in_ctx.tuser;
      ctx_last <= in_ctx.tlast;
    end
  end

  // ------------------------------
  // Output copies
  // ------------------------------

  assign out_a.tdata  = ctx_data;
  assign out_a.tuser  = ctx_user;
  assign out_a.tlast  = ctx_last;
  assign out_a.tvalid = pend_a;

  assign out_b.tdata  = ctx_data;
  assign out_b.tuser  = ctx_user;
  assign out_b.tlast  = ctx_last;
  assign out_b.tvalid = pend_b;

endmodule

// ==== src/addsub_block.sv ====
// Top of the two-stream add/subtract block with plain AXI-Stream ports for payload and context
module addsub_block
  import addsub_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  // Stream A payload
  input  sc16_t     in_a_tdata,
  input  logic      in_a_tlast,
  input  logic      in_a_tvalid,
  output logic      in_a_tready,
  // Stream B payload
  input  sc16_t     in_b_tdata,
  input  logic      in_b_tlast,
  input  logic      in_b_tvalid,
  output logic      in_b_tready,
  // Stream A context, B has none
  input  ctx_t      in_a_ctx_tdata,
  input  ctx_user_t in_a_ctx_tuser,
  input  logic      in_a_ctx_tlast,
  input  logic      in_a_ctx_tvalid,
  output logic      in_a_ctx_tready,
  // Sum payload
  output sc16_t     sum_tdata,
  output logic      sum_tlast,
  output logic      sum_tvalid,
  input  logic      sum_tready,
  // Difference payload
  output sc16_t     diff_tdata,
  output logic      diff_tlast,
  output logic      diff_tvalid,
  input  logic      diff_tready,
  // Sum context
  output ctx_t      sum_ctx_tdata,
  output ctx_user_t sum_ctx_tuser,
  output logic      sum_ctx_tlast,
  output logic      sum_ctx_tvalid,
  input  logic      sum_ctx_tready,
  // Difference context
  output ctx_t      diff_ctx_tdata,
  output ctx_user_t diff_ctx_tuser,
  output logic      diff_ctx_tlast,
  output logic      diff_ctx_tvalid,
  input  logic      diff_ctx_tready
);

  // ------------------------------
  // Internal streams
  // ------------------------------

  sample_stream_if in_a ();
  sample_stream_if in_b ();
  sample_stream_if sum ();
  sample_stream_if diff ();

  ctx_stream_if in_a_ctx ();
  ctx_stream_if sum_ctx ();
  ctx_stream_if diff_ctx ();

  // Payload inputs
  assign in_a.tdata  = in_a_tdata;
  assign in_a.tlast  = in_a_tlast;
  assign in_a.tvalid = in_a_tvalid;
  assign in_a_tready = in_a.tready;

  assign in_b.tdata  = in_b_tdata;
  assign in_b.tlast  = in_b_tlast;
  assign in_b.tvalid = in_b_tvalid;
  assign in_b_tready = in_b.tready;

  // Payload outputs
  assign sum_tdata   = sum.tdata;
  assign sum_tlast   = sum.tlast;
  assign sum_tvalid  = sum.tvalid;
  assign sum.tready  = sum_tready;

  assign diff_tdata  = diff.tdata;
  assign diff_tlast  = diff.tlast;
  assign diff_tvalid = diff.tvalid;
  assign diff.tready = diff_tready;

  // Context input, A drives framing for both outputs
  assign in_a_ctx.tdata  = in_a_ctx_tdata;
  assign in_a_ctx.tuser  = in_a_ctx_tuser;
  assign in_a_ctx.tlast  = in_a_ctx_tlast;
  assign in_a_ctx.tvalid = in_a_ctx_tvalid;
  assign in_a_ctx_tready = in_a_ctx.tready;

  // Context outputs
  assign sum_ctx_tdata    = sum_ctx.tdata;
  assign sum_ctx_tuser    = sum_ctx.tuser;
  assign sum_ctx_tlast    = sum_ctx.tlast;
  assign sum_ctx_tvalid   = sum_ctx.tvalid;
  assign sum_ctx.tready   = sum_ctx_tready;

  assign diff_ctx_tdata   = diff_ctx.tdata;
  assign diff_ctx_tuser   = diff_ctx.tuser;
  assign diff_ctx_tlast   = diff_ctx.tlast;
  assign diff_ctx_tvalid  = diff_ctx.tvalid;
  assign diff_ctx.tready  = diff_ctx_tready;

  // ------------------------------
  // Context duplication
  // ------------------------------

  ctx_split ctx_split_i (
    .clk    (clk),
    .rst    (rst),
    .in_ctx (in_a_ctx),
    .out_a  (sum_ctx),
    .out_b  (diff_ctx)
  );

  // ------------------------------
  // Add/subtract datapath
  // ------------------------------

  addsub_core addsub_core_i (
    .clk  (clk),
    .rst  (rst),
    .in_a (in_a),
    .in_b (in_b),
    .sum  (sum),
    .diff (diff)
  );

endmodule

// ==== bench/addsub_block_sva.sv ====
// Reset and output-hold assertions for addsub_block that bind attaches to every instance
module addsub_block_sva
  import addsub_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input sc16_t     sum_tdata,
  input logic      sum_tlast,
  input logic      sum_tvalid,
  input logic      sum_tready,
  input sc16_t     diff_tdata,
  input logic      diff_tlast,
  input logic      diff_tvalid,
  input logic      diff_tready,
  input ctx_t      sum_ctx_tdata,
  input ctx_user_t sum_ctx_tuser,
  input logic      sum_ctx_tlast,
  input logic      sum_ctx_tvalid,
  input logic      sum_ctx_tready,
  input ctx_t      diff_ctx_tdata,
  input ctx_user_t diff_ctx_tuser,
  input logic      diff_ctx_tlast,
  input logic      diff_ctx_tvalid,
  input logic      diff_ctx_tready
);
  timeunit 1ns;
  timeprecision 1ps;

  logic        any_vld;
  // Failed assertions so far, read by the testbench verdict
  int unsigned fail_cnt = 0;

  assign any_vld = sum_tvalid || diff_tvalid || sum_ctx_tvalid || diff_ctx_tvalid;

  // ------------------------------
  // Reset
  // ------------------------------

  // Every reset edge empties all output slots
  valid_low_in_reset: assert property (@(posedge clk) rst |=> !any_vld)
    else begin
      $error("output valid high after a reset edge");
      fail_cnt++;
    end

  // No input can be taken in the first cycle out of reset
  valid_low_after_reset: assert property (@(posedge clk) $fell(rst) |=> !any_vld)
    else begin
      $error("output valid high in the first cycle after reset");
      fail_cnt++;
    end

  // ------------------------------
  // Stalled beats hold
  // ------------------------------

  sum_hold: assert property (@(posedge clk) disable iff (rst)
    sum_tvalid && !sum_tready |=> sum_tvalid && $stable({sum_tdata, sum_tlast}))
    else begin
      $error("sum beat changed while stalled");
      fail_cnt++;
    end

  diff_hold: assert property (@(posedge clk) disable iff (rst)
    diff_tvalid && !diff_tready |=> diff_tvalid && $stable({diff_tdata, diff_tlast}))
    else begin
      $error("diff beat changed while stalled");
      fail_cnt++;
    end

  sum_ctx_hold: assert property (@(posedge clk) disable iff (rst)
    sum_ctx_tvalid && !sum_ctx_tready |=>
      sum_ctx_tvalid && $stable({sum_ctx_tdata, sum_ctx_tuser, sum_ctx_tlast}))
    else begin
      $error("sum context beat changed while stalled");
      fail_cnt++;
    end

  diff_ctx_hold: assert property (@(posedge clk) disable iff (rst)
    diff_ctx_tvalid && !diff_ctx_tready |=>
      diff_ctx_tvalid && $stable({diff_ctx_tdata, diff_ctx_tuser, diff_ctx_tlast}))
    else begin
      $error("diff context beat changed while stalled");
      fail_cnt++;
    end

endmodule

bind addsub_block addsub_block_sva addsub_block_sva_i (.*);

// ==== bench/addsub_block_tb.sv ====
// Top-level testbench that checks addsub_block with random packets against a reference model
`include "addsub_defines.svh"

module addsub_block_tb
  import addsub_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned TIMEOUT_CYC =
    `ADDSUB_NUM_PKTS * `ADDSUB_MAX_PKT_LEN * `ADDSUB_CYC_PER_BEAT;
  // Cycles the outputs get to empty once all inputs are sent
  localparam int unsigned DRAIN_CYC = 200;
  localparam int          LANE_MOD  = 1 << `ADDSUB_SAMP_W;

  logic        clk;
  logic        rst;
  // Payload inputs
  sc16_t       in_a_tdata;
  logic        in_a_tlast;
  logic        in_a_tvalid;
  logic        in_a_tready;
  sc16_t       in_b_tdata;
  logic        in_b_tlast;
  logic        in_b_tvalid;
  logic        in_b_tready;
  // Payload outputs
  sc16_t       sum_tdata;
  logic        sum_tlast;
  logic        sum_tvalid;
  logic        sum_tready;
  sc16_t       diff_tdata;
  logic        diff_tlast;
  logic        diff_tvalid;
  logic        diff_tready;
  // Context input
  ctx_t        in_a_ctx_tdata;
  ctx_user_t   in_a_ctx_tuser;
  logic        in_a_ctx_tlast;
  logic        in_a_ctx_tvalid;
  logic        in_a_ctx_tready;
  // Context outputs
  ctx_t        sum_ctx_tdata;
  ctx_user_t   sum_ctx_tuser;
  logic        sum_ctx_tlast;
  logic        sum_ctx_tvalid;
  logic        sum_ctx_tready;
  ctx_t        diff_ctx_tdata;
  ctx_user_t   diff_ctx_tuser;
  logic        diff_ctx_tlast;
  logic        diff_ctx_tvalid;
  logic        diff_ctx_tready;

  integer      seed = 68;

  // Framing of every payload beat is shared by A and B
  logic        pay_last[$];

  // Expected beats in order with one read position per output
  sc16_t       sum_exp[$];
  sc16_t       diff_exp[$];
  logic        last_exp[$];
  ctx_t        ctx_data_exp[$];
  ctx_user_t   ctx_user_exp[$];
  logic        ctx_last_exp[$];
  int unsigned sum_idx;
  int unsigned diff_idx;
  int unsigned sum_ctx_idx;
  int unsigned diff_ctx_idx;

  addsub_block addsub_block_i (.*);

  // ------------------------------
  // Reference model and checks
  // ------------------------------

  // Lane 0 is I and lane 1 is Q
  // Each lane wraps modulo 2^16
  function automatic void addsub_ref(input sc16_t a, input sc16_t b,
                                     output sc16_t s, output sc16_t d);
    int lane_a;
    int lane_b;
    for (int k = 0; k < 2; k++) begin
      lane_a = a[k*`ADDSUB_SAMP_W +: `ADDSUB_SAMP_W];
      lane_b = b[k*`ADDSUB_SAMP_W +: `ADDSUB_SAMP_W];
      s[k*`ADDSUB_SAMP_W +: `ADDSUB_SAMP_W] = (lane_a + lane_b) % LANE_MOD;
      d[k*`ADDSUB_SAMP_W +: `ADDSUB_SAMP_W] = (lane_a - lane_b + LANE_MOD) % LANE_MOD;
    end
  endfunction

  function automatic logic all_drained();
    return sum_idx == sum_exp.size() && diff_idx == diff_exp.size() &&
           sum_ctx_idx == ctx_data_exp.size() && diff_ctx_idx == ctx_data_exp.size();
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic require_beat(input logic have_exp, input string name);
    if (!have_exp) begin
      abort_run($sformatf("%s sent a beat that no accepted input accounts for", name));
    end
  endtask

  task automatic check_sample(input sc16_t got, input sc16_t exp, input logic got_last,
                              input logic exp_last, input string name);
    if (got !== exp || got_last !== exp_last) begin
      abort_run($sformatf("mismatch at %0d ns: %s got %h last %b, expected %h last %b",
                          $time, name, got, got_last, exp, exp_last));
    end
  endtask

  task automatic check_ctx(input ctx_t got_data, input ctx_t exp_data,
                           input ctx_user_t got_user, input ctx_user_t exp_user,
                           input logic got_last, input logic exp_last, input string name);
    if (got_data !== exp_data || got_user !== exp_user || got_last !== exp_last) begin
      abort_run($sformatf("mismatch at %0d ns: %s got %h/%h/%b, expected %h/%h/%b",
                          $time, name, got_data, got_user, got_last,
                          exp_data, exp_user, exp_last));
    end
  endtask

  // ------------------------------
  // Clock, watchdog, back-pressure
  // ------------------------------

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin : watchdog
    int unsigned cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYC) begin
      @(posedge clk);
      cycles++;
    end
    abort_run($sformatf("timeout: no verdict after %0d clock cycles", cycles));
  end

  // Independent random readies on all four outputs
  initial begin : ready_gen
    wait (!rst);
    forever begin
      @(negedge clk);
      sum_tready      = ($random(seed) & 1) != 0;
      diff_tready     = ($random(seed) & 1) != 0;
      sum_ctx_tready  = ($random(seed) & 1) != 0;
      diff_ctx_tready = ($random(seed) & 1) != 0;
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------

  // A and B each raise valid at random
  // A transfer is judged one time unit after the falling edge
  task automatic send_payload();
    int unsigned ia;
    int unsigned ib;
    logic        fire_a;
    logic        fire_b;
    ia     = 0;
    ib     = 0;
    fire_a = 1'b0;
    fire_b = 1'b0;
    while (ia < pay_last.size() || ib < pay_last.size()) begin
      @(negedge clk);
      if (fire_a) begin
        ia++;
        in_a_tvalid = 1'b0;
      end
      if (fire_b) begin
        ib++;
        in_b_tvalid = 1'b0;
      end
      if (ia < pay_last.size() && !in_a_tvalid && ($random(seed) & 3) != 0) begin
        in_a_tdata  = $random(seed);
        in_a_tlast  = pay_last[ia];
        in_a_tvalid = 1'b1;
      end
      if (ib < pay_last.size() && !in_b_tvalid && ($random(seed) & 3) != 0) begin
        in_b_tdata  = $random(seed);
        in_b_tlast  = pay_last[ib];
        in_b_tvalid = 1'b1;
      end
      #1;
      fire_a = in_a_tvalid && in_a_tready;
      fire_b = in_b_tvalid && in_b_tready;
    end
  endtask

  // Two context beats per packet with tlast on the second
  task automatic send_ctx();
    int unsigned ic;
    logic        fire;
    ic   = 0;
    fire = 1'b0;
    while (ic < `ADDSUB_NUM_PKTS * `ADDSUB_CTX_PER_PKT) begin
      @(negedge clk);
      if (fire) begin
        ic++;
        in_a_ctx_tvalid = 1'b0;
      end
      if (ic < `ADDSUB_NUM_PKTS * `ADDSUB_CTX_PER_PKT && !in_a_ctx_tvalid &&
          ($random(seed) & 3) != 0) begin
        in_a_ctx_tdata  = {$random(seed), $random(seed)};
        in_a_ctx_tuser  = ctx_user_t'($random(seed));
        in_a_ctx_tlast  = (ic % `ADDSUB_CTX_PER_PKT) == `ADDSUB_CTX_PER_PKT - 1;
        in_a_ctx_tvalid = 1'b1;
      end
      #1;
      fire = in_a_ctx_tvalid && in_a_ctx_tready;
    end
  endtask

  // ------------------------------
  // Scoreboard
  // ------------------------------

  initial begin : scoreboard
    sc16_t exp_s;
    sc16_t exp_d;
    forever begin
      @(negedge clk);
      // Handshakes hold still from here until the next rising edge
      #1;
      if (addsub_block_i.addsub_block_sva_i.fail_cnt != 0) begin
        abort_run("an assertion in the bound checker failed");
      end
      // Outputs go first since a pair accepted now shows up a cycle later
      if (sum_tvalid && sum_tready) begin
        require_beat(sum_idx < sum_exp.size(), "sum");
        check_sample(sum_tdata, sum_exp[sum_idx], sum_tlast, last_exp[sum_idx], "sum");
        sum_idx++;
      end
      if (diff_tvalid && diff_tready) begin
        require_beat(diff_idx < diff_exp.size(), "diff");
        check_sample(diff_tdata, diff_exp[diff_idx], diff_tlast, last_exp[diff_idx], "diff");
        diff_idx++;
      end
      if (sum_ctx_tvalid && sum_ctx_tready) begin
        require_beat(sum_ctx_idx < ctx_data_exp.size(), "sum_ctx");
        check_ctx(sum_ctx_tdata, ctx_data_exp[sum_ctx_idx], sum_ctx_tuser,
                  ctx_user_exp[sum_ctx_idx], sum_ctx_tlast, ctx_last_exp[sum_ctx_idx],
                  "sum_ctx");
        sum_ctx_idx++;
      end
      if (diff_ctx_tvalid && diff_ctx_tready) begin
        require_beat(diff_ctx_idx < ctx_data_exp.size(), "diff_ctx");
        check_ctx(diff_ctx_tdata, ctx_data_exp[diff_ctx_idx], diff_ctx_tuser,
                  ctx_user_exp[diff_ctx_idx], diff_ctx_tlast, ctx_last_exp[diff_ctx_idx],
                  "diff_ctx");
        diff_ctx_idx++;
      end
      // Input side
      if ((in_a_tvalid && in_a_tready) != (in_b_tvalid && in_b_tready)) begin
        abort_run("streams A and B were not consumed as a pair");
      end
      if (in_a_tvalid && in_a_tready) begin
        addsub_ref(in_a_tdata, in_b_tdata, exp_s, exp_d);
        sum_exp.push_back(exp_s);
        diff_exp.push_back(exp_d);
        last_exp.push_back(in_a_tlast);
      end
      if (in_a_ctx_tvalid && in_a_ctx_tready) begin
        ctx_data_exp.push_back(in_a_ctx_tdata);
        ctx_user_exp.push_back(in_a_ctx_tuser);
        ctx_last_exp.push_back(in_a_ctx_tlast);
      end
    end
  end

  // ------------------------------
  // Main sequence and verdict
  // ------------------------------

  initial begin : main
    int unsigned len;
    int unsigned wait_cyc;
    string       leftover;
    rst             = 1'b1;
    in_a_tdata      = '0;
    in_a_tlast      = 1'b0;
    in_a_tvalid     = 1'b0;
    in_b_tdata      = '0;
    in_b_tlast      = 1'b0;
    in_b_tvalid     = 1'b0;
    in_a_ctx_tdata  = '0;
    in_a_ctx_tuser  = '0;
    in_a_ctx_tlast  = 1'b0;
    in_a_ctx_tvalid = 1'b0;
    sum_tready      = 1'b0;
    diff_tready     = 1'b0;
    sum_ctx_tready  = 1'b0;
    diff_ctx_tready = 1'b0;
    // Random packet lengths from 1 to the maximum
    for (int p = 0; p < `ADDSUB_NUM_PKTS; p++) begin
      len = 1 + ($unsigned($random(seed)) % `ADDSUB_MAX_PKT_LEN);
      for (int k = 0; k < len; k++) begin
        pay_last.push_back(k == len - 1);
      end
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    fork
      send_payload();
      send_ctx();
    join
    wait_cyc = 0;
    while (wait_cyc < DRAIN_CYC && !all_drained()) begin
      @(negedge clk);
      wait_cyc++;
    end
    @(negedge clk);
    leftover = "";
    if (addsub_block_i.addsub_block_sva_i.fail_cnt != 0) begin
      leftover = "an assertion in the bound checker failed";
    end else if (sum_idx != sum_exp.size()) begin
      leftover = $sformatf("sum queue left %0d beats unread", sum_exp.size() - sum_idx);
    end else if (diff_idx != diff_exp.size()) begin
      leftover = $sformatf("diff queue left %0d beats unread", diff_exp.size() - diff_idx);
    end else if (sum_ctx_idx != ctx_data_exp.size()) begin
      leftover = "sum_ctx queue left beats unread";
    end else if (diff_ctx_idx != ctx_data_exp.size()) begin
      leftover = "diff_ctx queue left beats unread";
    end else if (sum_tvalid || diff_tvalid || sum_ctx_tvalid || diff_ctx_tvalid) begin
      leftover = "an output is still valid after every expected beat was seen";
    end
    if (leftover.len() != 0) begin
      abort_run(leftover);
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

// ==== vlog.f ====
+incdir+src
src/addsub_pkg.sv
src/addsub_ifs.sv
src/addsub_core.sv
src/ctx_split.sv
src/addsub_block.sv
bench/addsub_block_sva.sv
bench/addsub_block_tb.sv

// ==== Bender.yml ====
package:
  name: addsub_block

sources:
  - include_dirs:
      - src
    files:
      - src/addsub_pkg.sv
      - src/addsub_ifs.sv
      - src/addsub_core.sv
      - src/ctx_split.sv
      - src/addsub_block.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/addsub_block_sva.sv
      - bench/addsub_block_tb.sv
